/* include/rom_defs.svh */
// rom subsystem defines: address widths and counter sizes shared by all blocks
`ifndef ROM_DEFS_SVH
`define ROM_DEFS_SVH

// host download address, covers main rom and colour prom
`define ROM_PROG_AW 16

// main cpu address, 32 kB program space
`define ROM_MAIN_AW 15

// one main rom chip, 8 kB
`define ROM_CHIP_AW 13

// colour prom, 32 entries
`define ROM_PAL_AW 5

// accepted byte counter
`define ROM_COUNT_W 16

`endif

/* list.f */
+incdir+include
src/rom_bus_pkg.sv
src/rom_map_pkg.sv
src/rom_prom.sv
src/rom_loader.sv
src/rom_load_ctrl.sv
src/rom_main_bank.sv
src/rom_top.sv
tb/tb_rom_top.sv

/* src/rom_bus_pkg.sv */
// rom bus package: payload types carried between loader, proms and ports

package rom_bus_pkg;

    // full rom byte, download stream and main cpu data
    typedef logic [7:0] byte_t;

    // colour prom word, low nibble of a download byte
    typedef logic [3:0] nibble_t;

endpackage

/* src/rom_load_ctrl.sv */
// rom load control: download window register, accepted byte count and checksum
`timescale 1ns/1ps
`include "rom_defs.svh"

module rom_load_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    downloading,  // host window
    input  logic                    byte_done,    // from loader
    input  rom_bus_pkg::byte_t      byte_data,
    output logic                    load_en,      // downloading, one cycle late
    output logic [`ROM_COUNT_W-1:0] dl_count,     // accepted bytes
    output rom_bus_pkg::byte_t      dl_sum        // sum mod 256
);

    logic dl_rise;  // window opening

    assign dl_rise = downloading && !load_en;  // load_en is the previous value

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_en <= 1'b0;
        end else begin
            load_en <= downloading;
        end
    end

    // stats restart with each new download
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dl_count <= '0;
            dl_sum   <= '0;
        end else if (dl_rise) begin
            dl_count <= '0;
            dl_sum   <= '0;
        end else if (byte_done) begin
            dl_count <= dl_count + 1'b1;
            dl_sum   <= dl_sum + byte_data;  // wraps at 8 bits
        end
    end

endmodule

/* src/rom_loader.sv */
// rom loader: four-phase req/ack download receiver that issues prom write strobes
`timescale 1ns/1ps
`include "rom_defs.svh"

module rom_loader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,        // host request, four-phase
    input  logic                    load_en,    // download window from control block
    input  logic [`ROM_PROG_AW-1:0] prog_addr,  // stable while req high
    input  rom_bus_pkg::byte_t      prog_data,
    output logic                    ack,
    output logic [3:0]              main_we,    // one-hot chip strobe
    output logic                    pal_we,     // colour prom strobe
    output logic [`ROM_CHIP_AW-1:0] wr_addr,    // shared prom write address
    output rom_bus_pkg::byte_t      wr_data,
    output logic                    byte_done,  // accepted in-region byte
    output rom_bus_pkg::byte_t      byte_data
);

    typedef enum logic [1:0] {
        st_idle,  // waiting for req
        st_ack,   // ack just raised, strobe out
        st_wait   // holding ack until req drops
    } state_e;

    state_e                state;
    rom_map_pkg::region_e  region;
    rom_map_pkg::chip_t    chip;
    logic [`ROM_PROG_AW:0] addr_x;  // zero extended for region compare
    logic                  take;    // byte accepted this cycle

    assign addr_x = {1'b0, prog_addr};
    assign chip   = prog_addr[`ROM_CHIP_AW+1:`ROM_CHIP_AW];  // bits 14..13
    assign take   = (state == st_idle) && req && load_en;    // no ack outside window

    // address decode against the map
    always_comb begin
        if (addr_x >= rom_map_pkg::MAIN_BASE &&
            addr_x <  rom_map_pkg::MAIN_BASE + rom_map_pkg::MAIN_SIZE) begin
            region = rom_map_pkg::region_main;
        end else if (addr_x >= rom_map_pkg::PAL_BASE &&
                     addr_x <  rom_map_pkg::PAL_BASE + rom_map_pkg::PAL_SIZE) begin
            region = rom_map_pkg::region_palette;
        end else begin
            region = rom_map_pkg::region_none;  // acked, no write
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            ack       <= 1'b0;
            main_we   <= '0;
            pal_we    <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            main_we   <= '0;    // strobes last one cycle
            pal_we    <= 1'b0;
            byte_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (take) begin
                        state   <= st_ack;
                        ack     <= 1'b1;  // same edge as the strobe
                        if (region == rom_map_pkg::region_main) begin
                            main_we <= 4'b0001 << chip;
                        end
                        pal_we    <= (region == rom_map_pkg::region_palette);
                        byte_done <= (region != rom_map_pkg::region_none);
                    end
                end
                st_ack: begin
                    if (!req) begin
                        state <= st_idle;  // early drop
                        ack   <= 1'b0;
                    end else begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (!req) begin
                        state <= st_idle;
                        ack   <= 1'b0;  // host may raise req again after this
                    end
                end
                default: begin
                    state <= st_idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // payload capture, valid alongside the strobes
    always_ff @(posedge clk) begin
        if (take) begin
            wr_addr <= prog_addr[`ROM_CHIP_AW-1:0];
            wr_data <= prog_data;
        end
    end

    assign byte_data = wr_data;  // qualified by byte_done

endmodule

/* src/rom_main_bank.sv */
// rom main bank: four 8 kB program chips behind a registered bank multiplexer
`timescale 1ns/1ps
`include "rom_defs.svh"

module rom_main_bank (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [3:0]              main_we,    // one-hot chip write
    input  logic [`ROM_CHIP_AW-1:0] wr_addr,
    input  rom_bus_pkg::byte_t      wr_data,
    input  logic                    main_cs,    // cpu select, gates the output reg
    input  logic [`ROM_MAIN_AW-1:0] main_addr,  // 32 kB byte address
    output rom_bus_pkg::byte_t      main_dout
);

    rom_bus_pkg::byte_t chip_q [4];  // per chip registered read
    rom_map_pkg::chip_t sel_q;       // chip index, aligned to chip_q

    for (genvar i = 0; i < 4; i++) begin : g_chip
        rom_prom #(
            .aw     (`ROM_CHIP_AW),
            .word_t (rom_bus_pkg::byte_t)
        ) u_prom (
            .clk     (clk),
            .rd_addr (main_addr[`ROM_CHIP_AW-1:0]),  // low 13 bits to every chip
            .wr_addr (wr_addr),
            .data    (wr_data),
            .we      (main_we[i]),
            .q       (chip_q[i])
        );
    end

    // delay chip select to match the prom read register
    always_ff @(posedge clk) begin
        sel_q <= main_addr[`ROM_MAIN_AW-1:`ROM_CHIP_AW];
    end

    // second stage, holds while cs low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_dout <= '0;
        end else if (main_cs) begin
            main_dout <= chip_q[sel_q];
        end
    end

endmodule

/* src/rom_map_pkg.sv */
// rom map package: download address regions, region bases and chip index
`include "rom_defs.svh"

package rom_map_pkg;

    // what a download address lands in
    typedef enum logic [1:0] {
        region_main    = 2'd0,  // one of the four program chips
        region_palette = 2'd1,  // colour prom, low nibble only
        region_none    = 2'd2   // unmapped, acked and dropped
    } region_e;

    // main rom chip select, download address bits 14..13
    typedef logic [1:0] chip_t;

    // one bit wider than the download address so base + size never wraps
    localparam logic [`ROM_PROG_AW:0] MAIN_BASE = 17'h0_0000;
    localparam logic [`ROM_PROG_AW:0] MAIN_SIZE = 17'h0_8000;  // 4 x 8 kB

    localparam logic [`ROM_PROG_AW:0] PAL_BASE  = 17'h0_8000;  // right after main
    localparam logic [`ROM_PROG_AW:0] PAL_SIZE  = 17'd32;      // 32 x 4 bit

endpackage

/* src/rom_prom.sv */
// rom prom: synchronous prom with registered read and a write port for loading
`timescale 1ns/1ps

module rom_prom #(
    parameter int  aw     = 13,                   // address bits
    parameter type word_t = rom_bus_pkg::byte_t   // stored word
) (
    input  logic          clk,
    input  logic [aw-1:0] rd_addr,   // cpu / video side
    input  logic [aw-1:0] wr_addr,   // download side
    input  word_t         data,      // download payload
    input  logic          we,        // one cycle strobe from loader
    output word_t         q          // registered read data
);

    // contents undefined until downloaded
    word_t mem [2**aw];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;  // download write
        end
    end

    always_ff @(posedge clk) begin
        q <= mem[rd_addr];  // read every cycle, one cycle latency
    end

endmodule

/* src/rom_top.sv */
// rom top: joins loader, load control, main program bank and colour prom
`timescale 1ns/1ps
`include "rom_defs.svh"

module rom_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // host download, four-phase
    input  logic                    req,
    output logic                    ack,
    input  logic                    downloading,
    input  logic [`ROM_PROG_AW-1:0] prog_addr,
    input  rom_bus_pkg::byte_t      prog_data,
    // main cpu
    input  logic                    main_cs,
    input  logic [`ROM_MAIN_AW-1:0] main_addr,
    output rom_bus_pkg::byte_t      main_dout,
    // colour lookup
    input  logic [`ROM_PAL_AW-1:0]  pal_addr,
    output rom_bus_pkg::nibble_t    pal_dout,
    // download check
    output logic [`ROM_COUNT_W-1:0] dl_count,
    output rom_bus_pkg::byte_t      dl_sum
);

    logic                    load_en;
    logic [3:0]              main_we;
    logic                    pal_we;
    logic [`ROM_CHIP_AW-1:0] wr_addr;
    rom_bus_pkg::byte_t      wr_data;
    logic                    byte_done;
    rom_bus_pkg::byte_t      byte_data;

    rom_loader u_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .load_en   (load_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ack       (ack),
        .main_we   (main_we),
        .pal_we    (pal_we),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .byte_done (byte_done),
        .byte_data (byte_data)
    );

    rom_load_ctrl u_load_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .byte_done   (byte_done),
        .byte_data   (byte_data),
        .load_en     (load_en),
        .dl_count    (dl_count),
        .dl_sum      (dl_sum)
    );

    rom_main_bank u_main_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .main_we   (main_we),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .main_cs   (main_cs),
        .main_addr (main_addr),
        .main_dout (main_dout)
    );

    // colour prom keeps only the low nibble
    rom_prom #(
        .aw     (`ROM_PAL_AW),
        .word_t (rom_bus_pkg::nibble_t)
    ) u_pal_prom (
        .clk     (clk),
        .rd_addr (pal_addr),
        .wr_addr (wr_addr[`ROM_PAL_AW-1:0]),
        .data    (wr_data[3:0]),
        .we      (pal_we),
        .q       (pal_dout)
    );

endmodule

/* tb/tb_rom_top.sv */
// rom top testbench: host download model, reference memories and protocol assertions
`timescale 1ns/1ps
`include "rom_defs.svh"

module tb_rom_top;

    localparam int n_main  = 200;                    // main rom bytes
    localparam int n_pal   = 32;                     // whole colour prom
    localparam int n_oor   = 8;                      // bytes past the colour region
    localparam int n_xfer  = 1 + n_main + n_pal + n_oor;
    localparam int n_reads = n_main + n_pal;
    localparam int limit   = n_xfer * 8 + n_reads * 4 + 200;

    logic                    clk;
    logic                    rst_n;
    logic                    req;
    logic                    ack;
    logic                    downloading;
    logic [`ROM_PROG_AW-1:0] prog_addr;
    rom_bus_pkg::byte_t      prog_data;
    logic                    main_cs;
    logic [`ROM_MAIN_AW-1:0] main_addr;
    rom_bus_pkg::byte_t      main_dout;
    logic [`ROM_PAL_AW-1:0]  pal_addr;
    rom_bus_pkg::nibble_t    pal_dout;
    logic [`ROM_COUNT_W-1:0] dl_count;
    rom_bus_pkg::byte_t      dl_sum;

    rom_bus_pkg::byte_t      ref_mem [int];   // main rom model, by download address
    rom_bus_pkg::nibble_t    pal_ref [32];    // colour prom model
    logic [`ROM_MAIN_AW-1:0] rd_list [$];     // main addresses to read back
    logic [`ROM_COUNT_W-1:0] exp_count;
    rom_bus_pkg::byte_t      exp_sum;
    rom_bus_pkg::byte_t      exp_main;        // expected byte for main_addr
    rom_bus_pkg::nibble_t    exp_pal;         // expected nibble for pal_addr
    logic                    started;         // first req raised
    logic                    rd_chk;          // main read in flight
    logic                    pal_chk;         // colour read in flight
    logic                    oor;             // current byte outside every region
    logic                    stats_chk;       // compare count and sum now
    logic [31:0]             lcg_state;
    int                      cycles;

    rom_top u_rom_top (.*);

    always #4 clk = ~clk;  // 8 ns period

    // first failure ends the run
    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];  // upper bits, better spread
    endfunction

    // next edge plus 1 ns, outputs settled and inputs safe to change
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // raise req and record what the byte should do
    task automatic start_req(input logic [15:0] addr, input rom_bus_pkg::byte_t data);
        prog_addr = addr;
        prog_data = data;
        req       = 1'b1;
        started   = 1'b1;
        oor       = (addr >= 16'h8020);
        if (addr < 16'h8000) begin
            ref_mem[int'(addr)] = data;  // main rom
            exp_count = exp_count + 1'b1;
            exp_sum   = exp_sum + data;
        end else if (addr < 16'h8020) begin
            pal_ref[addr[4:0]] = data[3:0];  // low nibble kept
            exp_count = exp_count + 1'b1;
            exp_sum   = exp_sum + data;      // full byte in the checksum
        end
    endtask

    // wait for ack, drop req, wait for ack low
    task automatic finish_req();
        while (!ack) step();
        req = 1'b0;
        while (ack) step();
        oor = 1'b0;
    endtask

    task automatic send_byte(input logic [15:0] addr, input rom_bus_pkg::byte_t data);
        start_req(addr, data);
        finish_req();
    endtask

    // protocol and data checks
    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!ack && main_dout == '0))
        else report_error("ack or main_dout not idle after reset");
    a_no_ack_closed: assert property (@(posedge clk) disable iff (!rst_n)
        !downloading |-> ##2 !$rose(ack))
        else report_error("ack raised while downloading low");
    a_ack_on_open: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(downloading) && req) |-> ##[1:4] ack)
        else report_error("pending req not acked after downloading rose");
    a_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && !req) |=> !ack)
        else report_error("ack did not fall after req dropped");
    a_main_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_chk ##1 main_cs |=> main_dout == $past(exp_main, 2))
        else report_error("main_dout differs from reference byte");
    a_main_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !main_cs |=> $stable(main_dout))
        else report_error("main_dout changed with main_cs low");
    a_pal_data: assert property (@(posedge clk) disable iff (!rst_n)
        pal_chk |=> pal_dout == $past(exp_pal))
        else report_error("pal_dout differs from reference nibble");
    a_oor_count: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(ack) && oor) |=> $stable(dl_count))
        else report_error("out of region byte changed dl_count");
    a_stats: assert property (@(posedge clk) disable iff (!rst_n)
        stats_chk |-> (dl_count == exp_count && dl_sum == exp_sum))
        else report_error("dl_count or dl_sum differs from expected");
    a_stats_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(downloading) |=> (dl_count == '0 && dl_sum == '0))
        else report_error("stats not cleared on new download");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    initial begin
        logic [15:0] rnd;
        logic [15:0] addr;
        clk = 1'b0;
        rst_n = 1'b0;
        req = 1'b0;
        downloading = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        main_cs = 1'b0;
        main_addr = '0;
        pal_addr = '0;
        exp_count = '0;
        exp_sum = '0;
        exp_main = '0;
        exp_pal = '0;
        started = 1'b0;
        rd_chk = 1'b0;
        pal_chk = 1'b0;
        oor = 1'b0;
        stats_chk = 1'b0;
        lcg_state = 32'd21;  // seed
        cycles = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) step();  // idle check window

        // req held with the window closed, then opened
        start_req(16'h0123, 8'h5a);
        repeat (20) step();
        downloading = 1'b1;
        finish_req();

        // main rom, chip index cycles through all four
        for (int i = 0; i < n_main; i++) begin
            rnd  = lcg_next();
            addr = {1'b0, i[1:0], rnd[12:0]};
            rd_list.push_back(addr[14:0]);
            rnd = lcg_next();
            send_byte(addr, rnd[7:0]);
        end

        // colour prom, full bytes sent
        for (int i = 0; i < n_pal; i++) begin
            rnd = lcg_next();
            send_byte(16'h8000 + i[15:0], rnd[7:0]);
        end

        // unmapped bytes, acked only
        for (int i = 0; i < n_oor; i++) begin
            rnd  = lcg_next();
            addr = 16'h8020 + (rnd % 16'h7fe0);
            rnd  = lcg_next();
            send_byte(addr, rnd[7:0]);
        end

        // one main address per cycle
        main_cs = 1'b1;
        foreach (rd_list[k]) begin
            main_addr = rd_list[k];
            exp_main  = ref_mem[int'(rd_list[k])];
            rd_chk    = 1'b1;
            step();
        end
        rd_chk = 1'b0;
        repeat (2) step();  // drain the two reads in flight
        main_cs = 1'b0;
        repeat (4) begin
            rnd = lcg_next();
            main_addr = rnd[14:0];  // dout must hold
            step();
        end

        for (int i = 0; i < n_pal; i++) begin
            pal_addr = i[4:0];
            exp_pal  = pal_ref[i];
            pal_chk  = 1'b1;
            step();
        end
        pal_chk = 1'b0;

        repeat (3) step();
        stats_chk = 1'b1;
        step();
        stats_chk = 1'b0;

        // close and reopen the window
        downloading = 1'b0;
        repeat (3) step();
        downloading = 1'b1;
        repeat (4) step();

        $display("Testbench passed");
        $finish;
    end

endmodule
